// ==== hdl/fcs_defines.svh ====
// FCS inserter constants: lane count, CRC-32 seed and polynomial, FCS length
`ifndef FCS_DEFINES_SVH
`define FCS_DEFINES_SVH

// bytes per 64-bit beat
`define FCS_LANES 8

// CRC register start value
`define FCS_CRC_SEED 32'hffff_ffff

// Ethernet CRC-32 polynomial, bit-reversed for LSB-first processing
`define FCS_CRC_POLY 32'hedb8_8320

// FCS appended after the frame
`define FCS_BYTES 4

`endif

// ==== hdl/axis_types_pkg.sv ====
// stream types for the 64-bit byte-lane data path
`default_nettype none

`include "fcs_defines.svh"

package axis_types_pkg;

    // one beat of stream data
    typedef logic [`FCS_LANES*8-1:0] axis_data_t;

    // byte-valid mask, valid lanes always packed at the bottom
    typedef logic [`FCS_LANES-1:0] axis_keep_t;

    // number of valid bytes in a beat, 0 to 8
    typedef logic [3:0] lane_count_t;

endpackage

`default_nettype wire

// ==== hdl/fcs_pkg.sv ====
// CRC value type and frame FSM states for the FCS inserter
`default_nettype none

package fcs_pkg;

    // running or final CRC-32 value
    typedef logic [31:0] crc_t;

    // frame sequencing
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PAYLOAD,
        ST_FCS
    } fcs_state_t;

endpackage

`default_nettype wire

// ==== hdl/eth_crc32_64.sv ====
// running Ethernet CRC-32 over the kept byte lanes of each 64-bit beat
`default_nettype none

`include "fcs_defines.svh"

module eth_crc32_64 (
    input  logic                      clk,
    input  logic                      rst,
    input  axis_types_pkg::axis_data_t data,
    input  axis_types_pkg::axis_keep_t keep,
    input  logic                      crc_clear,
    input  logic                      crc_update,
    output fcs_pkg::crc_t             crc_next
);

    import fcs_pkg::*;

    crc_t crc_q;

    // fold the kept lanes in, low lane first, one bit at a time
    always_comb begin
        crc_t c;
        c = crc_q;
        for (int lane = 0; lane < `FCS_LANES; lane++) begin
            if (keep[lane]) begin
                c[7:0] = c[7:0] ^ data[lane*8 +: 8];
                for (int b = 0; b < 8; b++) begin
                    if (c[0]) begin
                        c = (c >> 1) ^ `FCS_CRC_POLY;
                    end else begin
                        c = c >> 1;
                    end
                end
            end
        end
        crc_next = c;
    end

    // clear wins over update, so the last beat of a frame restarts the CRC
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_q <= `FCS_CRC_SEED;
        end else if (crc_clear) begin
            crc_q <= `FCS_CRC_SEED;
        end else if (crc_update) begin
            crc_q <= crc_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fcs_tail_merge.sv ====
// merges the complemented CRC into the last beat and an optional extra beat
`default_nettype none

`include "fcs_defines.svh"

module fcs_tail_merge (
    input  axis_types_pkg::axis_data_t data,
    input  axis_types_pkg::axis_keep_t keep,
    input  fcs_pkg::crc_t             crc_next,
    output axis_types_pkg::axis_data_t word0,
    output axis_types_pkg::axis_data_t word1,
    output axis_types_pkg::axis_keep_t keep0,
    output axis_types_pkg::axis_keep_t keep1
);

    import axis_types_pkg::*;
    import fcs_pkg::*;

    lane_count_t lane_cnt;
    crc_t        fcs;

    // keep is contiguous from lane 0, so a popcount gives the byte count
    always_comb begin
        lane_cnt = '0;
        for (int i = 0; i < `FCS_LANES; i++) begin
            lane_cnt = lane_cnt + lane_count_t'(keep[i]);
        end
    end

    assign fcs = ~crc_next;

    // FCS goes out LSB first, starting at the first free lane
    always_comb begin
        int pos;
        word0 = data;
        keep0 = keep;
        word1 = '0;
        keep1 = '0;
        for (int b = 0; b < `FCS_BYTES; b++) begin
            pos = int'(lane_cnt) + b;
            if (pos < `FCS_LANES) begin
                word0[pos*8 +: 8] = fcs[b*8 +: 8];
                keep0[pos]        = 1'b1;
            end else begin
                // spill into the extra beat
                word1[(pos-`FCS_LANES)*8 +: 8] = fcs[b*8 +: 8];
                keep1[pos-`FCS_LANES]          = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fcs_insert_fsm.sv ====
// frame FSM: masks input lanes, steers payload, FCS tail and extra FCS beat
`default_nettype none

`include "fcs_defines.svh"

module fcs_insert_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  axis_types_pkg::axis_data_t in_tdata,
    input  axis_types_pkg::axis_keep_t in_tkeep,
    input  logic                      in_tvalid,
    output logic                      in_tready,
    input  logic                      in_tlast,
    input  logic                      in_tuser,
    output logic                      crc_clear,
    output logic                      crc_update,
    output axis_types_pkg::axis_data_t masked_data,
    output axis_types_pkg::axis_keep_t masked_keep,
    input  axis_types_pkg::axis_data_t word0,
    input  axis_types_pkg::axis_data_t word1,
    input  axis_types_pkg::axis_keep_t keep0,
    input  axis_types_pkg::axis_keep_t keep1,
    output axis_types_pkg::axis_data_t int_tdata,
    output axis_types_pkg::axis_keep_t int_tkeep,
    output logic                      int_tvalid,
    output logic                      int_tlast,
    output logic                      int_tuser,
    input  logic                      ready_early,
    input  logic                      ready_int,
    output logic                      busy
);

    import axis_types_pkg::*;
    import fcs_pkg::*;

    fcs_state_t state_q;
    fcs_state_t state_d;
    logic       tready_d;
    logic       xfer;
    logic       load_extra;
    axis_data_t extra_data_q;
    axis_keep_t extra_keep_q;

    // zero the lanes whose keep bit is low
    always_comb begin
        for (int i = 0; i < `FCS_LANES; i++) begin
            masked_data[i*8 +: 8] = in_tkeep[i] ? in_tdata[i*8 +: 8] : 8'd0;
        end
    end

    assign masked_keep = in_tkeep;
    assign xfer        = in_tvalid & in_tready;

    always_comb begin
        state_d    = state_q;
        tready_d   = 1'b0;
        crc_clear  = 1'b0;
        crc_update = 1'b0;
        load_extra = 1'b0;
        int_tdata  = masked_data;
        int_tkeep  = in_tkeep;
        int_tvalid = 1'b0;
        int_tlast  = 1'b0;
        int_tuser  = 1'b0;
        case (state_q)
            ST_FCS: begin
                // extra beat holding the FCS bytes that did not fit
                int_tdata  = extra_data_q;
                int_tkeep  = extra_keep_q;
                int_tvalid = 1'b1;
                int_tlast  = 1'b1;
                if (ready_int) begin
                    tready_d = ready_early;
                    state_d  = ST_IDLE;
                end
            end
            default: begin
                tready_d   = ready_early;
                int_tvalid = xfer;
                // keep the CRC at its seed between frames
                crc_clear  = (state_q == ST_IDLE) && !xfer;
                if (xfer) begin
                    crc_update = 1'b1;
                    state_d    = ST_PAYLOAD;
                    if (in_tlast && in_tuser) begin
                        // bad frame, pass it on marked and without FCS
                        int_tlast = 1'b1;
                        int_tuser = 1'b1;
                        crc_clear = 1'b1;
                        state_d   = ST_IDLE;
                    end else if (in_tlast) begin
                        int_tdata  = word0;
                        int_tkeep  = keep0;
                        crc_clear  = 1'b1;
                        load_extra = 1'b1;
                        if (keep1 == '0) begin
                            int_tlast = 1'b1;
                            state_d   = ST_IDLE;
                        end else begin
                            tready_d = 1'b0;
                            state_d  = ST_FCS;
                        end
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            in_tready <= 1'b0;
            busy      <= 1'b0;
        end else begin
            state_q   <= state_d;
            in_tready <= tready_d;
            busy      <= state_d != ST_IDLE;
        end
    end

    // remainder of the FCS for the extra beat
    always_ff @(posedge clk) begin
        if (load_extra) begin
            extra_data_q <= word1;
            extra_keep_q <= keep1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/axis_skid_reg.sv ====
// registered stream output with a holding entry to absorb back-pressure
`default_nettype none

module axis_skid_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  axis_types_pkg::axis_data_t int_tdata,
    input  axis_types_pkg::axis_keep_t int_tkeep,
    input  logic                      int_tvalid,
    input  logic                      int_tlast,
    input  logic                      int_tuser,
    output logic                      ready_early,
    output logic                      ready_int,
    output axis_types_pkg::axis_data_t out_tdata,
    output axis_types_pkg::axis_keep_t out_tkeep,
    output logic                      out_tvalid,
    input  logic                      out_tready,
    output logic                      out_tlast,
    output logic                      out_tuser
);

    import axis_types_pkg::*;

    axis_data_t hold_tdata;
    axis_keep_t hold_tkeep;
    logic       hold_tvalid;
    logic       hold_tlast;
    logic       hold_tuser;
    logic       to_out;

    // safe to accept next cycle unless both entries could end up full
    assign ready_early = out_tready | (~hold_tvalid & (~out_tvalid | ~int_tvalid));

    // incoming beat goes straight to the output entry when it is free
    assign to_out = out_tready | ~out_tvalid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_int   <= 1'b0;
            out_tvalid  <= 1'b0;
            hold_tvalid <= 1'b0;
        end else begin
            ready_int <= ready_early;
            if (ready_int) begin
                if (to_out) begin
                    out_tvalid <= int_tvalid;
                end else begin
                    hold_tvalid <= int_tvalid;
                end
            end else if (out_tready) begin
                // drain the holding entry
                out_tvalid  <= hold_tvalid;
                hold_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready_int) begin
            if (to_out) begin
                out_tdata <= int_tdata;
                out_tkeep <= int_tkeep;
                out_tlast <= int_tlast;
                out_tuser <= int_tuser;
            end else begin
                hold_tdata <= int_tdata;
                hold_tkeep <= int_tkeep;
                hold_tlast <= int_tlast;
                hold_tuser <= int_tuser;
            end
        end else if (out_tready) begin
            out_tdata <= hold_tdata;
            out_tkeep <= hold_tkeep;
            out_tlast <= hold_tlast;
            out_tuser <= hold_tuser;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/eth_fcs_insert_64.sv ====
// Ethernet FCS inserter top level for a 64-bit byte-lane stream
`default_nettype none

module eth_fcs_insert_64 (
    input  logic                      clk,
    input  logic                      rst,
    input  axis_types_pkg::axis_data_t in_tdata,
    input  axis_types_pkg::axis_keep_t in_tkeep,
    input  logic                      in_tvalid,
    output logic                      in_tready,
    input  logic                      in_tlast,
    input  logic                      in_tuser,
    output axis_types_pkg::axis_data_t out_tdata,
    output axis_types_pkg::axis_keep_t out_tkeep,
    output logic                      out_tvalid,
    input  logic                      out_tready,
    output logic                      out_tlast,
    output logic                      out_tuser,
    output logic                      busy
);

    import axis_types_pkg::*;
    import fcs_pkg::*;

    axis_data_t masked_data;
    axis_keep_t masked_keep;
    axis_data_t word0;
    axis_data_t word1;
    axis_keep_t keep0;
    axis_keep_t keep1;
    axis_data_t int_tdata;
    axis_keep_t int_tkeep;
    crc_t       crc_next;
    logic       crc_clear;
    logic       crc_update;
    logic       int_tvalid;
    logic       int_tlast;
    logic       int_tuser;
    logic       ready_early;
    logic       ready_int;

    fcs_insert_fsm fsm0 (
        .clk(clk), .rst(rst),
        .in_tdata(in_tdata), .in_tkeep(in_tkeep), .in_tvalid(in_tvalid),
        .in_tready(in_tready), .in_tlast(in_tlast), .in_tuser(in_tuser),
        .crc_clear(crc_clear), .crc_update(crc_update),
        .masked_data(masked_data), .masked_keep(masked_keep),
        .word0(word0), .word1(word1), .keep0(keep0), .keep1(keep1),
        .int_tdata(int_tdata), .int_tkeep(int_tkeep), .int_tvalid(int_tvalid),
        .int_tlast(int_tlast), .int_tuser(int_tuser),
        .ready_early(ready_early), .ready_int(ready_int), .busy(busy)
    );

    eth_crc32_64 crc0 (
        .clk(clk), .rst(rst),
        .data(masked_data), .keep(masked_keep),
        .crc_clear(crc_clear), .crc_update(crc_update), .crc_next(crc_next)
    );

    fcs_tail_merge merge0 (
        .data(masked_data), .keep(masked_keep), .crc_next(crc_next),
        .word0(word0), .word1(word1), .keep0(keep0), .keep1(keep1)
    );

    axis_skid_reg skid0 (
        .clk(clk), .rst(rst),
        .int_tdata(int_tdata), .int_tkeep(int_tkeep), .int_tvalid(int_tvalid),
        .int_tlast(int_tlast), .int_tuser(int_tuser),
        .ready_early(ready_early), .ready_int(ready_int),
        .out_tdata(out_tdata), .out_tkeep(out_tkeep), .out_tvalid(out_tvalid),
        .out_tready(out_tready), .out_tlast(out_tlast), .out_tuser(out_tuser)
    );

endmodule

`default_nettype wire

// ==== tests/fcs_frame_table.svh ====
// stimulus table for the FCS inserter testbench
// columns: test name, first and last frame length in bytes, tuser on first frame, random stalls
// one frame per length in the range, sent back to back
task automatic load_frame_table();
    add_row("single_beat", 1, 8, 1'b0, 1'b0);
    add_row("tail_positions", 9, 16, 1'b0, 1'b0);
    add_row("min_length", 60, 64, 1'b0, 1'b0);
    add_row("tuser_then_good", 11, 12, 1'b1, 1'b0);
    add_row("tuser_short", 3, 4, 1'b1, 1'b0);
    add_row("stall_b2b", 5, 20, 1'b0, 1'b1);
    add_row("stall_error", 17, 19, 1'b1, 1'b1);
    add_row("stall_long", 60, 64, 1'b0, 1'b1);
endtask

// ==== tests/tb_eth_fcs_insert_64.sv ====
// testbench for the Ethernet FCS inserter with table driven frames and a reference CRC
`default_nettype none

`include "fcs_defines.svh"

module tb_eth_fcs_insert_64;

    import axis_types_pkg::*;
    import fcs_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        rst;
    axis_data_t  in_tdata;
    axis_keep_t  in_tkeep;
    logic        in_tvalid;
    logic        in_tready;
    logic        in_tlast;
    logic        in_tuser;
    axis_data_t  out_tdata;
    axis_keep_t  out_tkeep;
    logic        out_tvalid;
    logic        out_tready;
    logic        out_tlast;
    logic        out_tuser;
    logic        busy;
    logic [31:0] lfsr_q;
    int          errors;
    int          passed;
    int          failed;
    bit          busy_seen;
    string       row_name [$];
    int          row_first [$];
    int          row_last [$];
    bit          row_bad [$];
    bit          row_stall [$];
    axis_data_t  in_data_q [$];
    axis_keep_t  in_keep_q [$];
    bit          in_last_q [$];
    bit          in_user_q [$];
    axis_data_t  exp_data_q [$];
    axis_keep_t  exp_keep_q [$];
    bit          exp_last_q [$];
    bit          exp_user_q [$];

    `include "fcs_frame_table.svh"

    eth_fcs_insert_64 dut0 (
        .clk(clk), .rst(rst),
        .in_tdata(in_tdata), .in_tkeep(in_tkeep), .in_tvalid(in_tvalid),
        .in_tready(in_tready), .in_tlast(in_tlast), .in_tuser(in_tuser),
        .out_tdata(out_tdata), .out_tkeep(out_tkeep), .out_tvalid(out_tvalid),
        .out_tready(out_tready), .out_tlast(out_tlast), .out_tuser(out_tuser),
        .busy(busy)
    );

    always #4 clk = ~clk;

    task automatic add_row(input string name, input int first, input int last,
                           input bit bad, input bit stall);
        row_name.push_back(name);
        row_first.push_back(first);
        row_last.push_back(last);
        row_bad.push_back(bad);
        row_stall.push_back(stall);
    endtask

    // Galois LFSR stepped once per bit drawn
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // bit-serial CRC-32 taking each byte LSB first and returning the complement
    function automatic crc_t ref_fcs(input byte_q_t bytes);
        crc_t c;
        logic fb;
        c = `FCS_CRC_SEED;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ bytes[i][b];
                c = c >> 1;
                if (fb) begin
                    c = c ^ `FCS_CRC_POLY;
                end
            end
        end
        return ~c;
    endfunction

    task automatic check_data(input string name, input axis_data_t exp, input axis_data_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_keep(input string name, input axis_keep_t exp, input axis_keep_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic pack_beat(input byte_q_t bytes, input int base, input bit junk,
                             output axis_data_t d, output axis_keep_t k);
        d = '0;
        k = '0;
        for (int j = 0; j < `FCS_LANES; j++) begin
            if (base + j < bytes.size()) begin
                d[j*8 +: 8] = bytes[base+j];
                k[j] = 1'b1;
            end else if (junk) begin
                // noise the DUT has to zero
                d[j*8 +: 8] = 8'(rand_bits(8));
            end
        end
    endtask

    task automatic build_frame(input int len, input bit bad);
        byte_q_t    bytes;
        crc_t       fcs;
        axis_data_t d;
        axis_keep_t k;
        bit         last;
        bytes = {};
        for (int i = 0; i < len; i++) begin
            bytes.push_back(8'(rand_bits(8)));
        end
        for (int i = 0; i < len; i += `FCS_LANES) begin
            pack_beat(bytes, i, 1'b1, d, k);
            last = i + `FCS_LANES >= len;
            in_data_q.push_back(d);
            in_keep_q.push_back(k);
            in_last_q.push_back(last);
            in_user_q.push_back(bad && last);
        end
        // good frames carry the FCS after the payload
        if (!bad) begin
            fcs = ref_fcs(bytes);
            for (int b = 0; b < `FCS_BYTES; b++) begin
                bytes.push_back(fcs[b*8 +: 8]);
            end
        end
        for (int i = 0; i < bytes.size(); i += `FCS_LANES) begin
            pack_beat(bytes, i, 1'b0, d, k);
            last = i + `FCS_LANES >= bytes.size();
            exp_data_q.push_back(d);
            exp_keep_q.push_back(k);
            exp_last_q.push_back(last);
            exp_user_q.push_back(bad && last);
        end
    endtask

    task automatic drive_beats(input string name, input bit stall, input logic [31:0] gaps);
        bit hold;
        int cyc;
        for (cyc = 0; cyc < TIMEOUT && in_data_q.size() > 0; cyc++) begin
            @(posedge clk);
            hold = in_tvalid && !in_tready;
            if (in_tvalid && in_tready) begin
                void'(in_data_q.pop_front());
                void'(in_keep_q.pop_front());
                void'(in_last_q.pop_front());
                void'(in_user_q.pop_front());
            end
            // a beat once offered stays until accepted
            if (in_data_q.size() > 0 && (hold || !(stall && gaps[cyc[4:0]]))) begin
                in_tdata  <= in_data_q[0];
                in_tkeep  <= in_keep_q[0];
                in_tlast  <= in_last_q[0];
                in_tuser  <= in_user_q[0];
                in_tvalid <= 1'b1;
            end else begin
                in_tvalid <= 1'b0;
            end
        end
        if (in_data_q.size() > 0) begin
            $display("%s: input beats were not accepted before the timeout", name);
            errors++;
        end
    endtask

    task automatic collect_beats(input string name, input bit stall, input logic [31:0] stalls);
        string tag;
        int    cnt;
        int    cyc;
        cnt = 0;
        for (cyc = 0; cyc < TIMEOUT && exp_data_q.size() > 0; cyc++) begin
            @(posedge clk);
            busy_seen = busy_seen | busy;
            if (out_tvalid && out_tready) begin
                tag = $sformatf("%s beat %0d", name, cnt);
                check_data({tag, " tdata"}, exp_data_q.pop_front(), out_tdata);
                check_keep({tag, " tkeep"}, exp_keep_q.pop_front(), out_tkeep);
                check_flag({tag, " tlast"}, exp_last_q.pop_front(), out_tlast);
                check_flag({tag, " tuser"}, exp_user_q.pop_front(), out_tuser);
                cnt++;
            end
            out_tready <= !(stall && stalls[cyc[4:0]]);
        end
        out_tready <= 1'b1;
        if (exp_data_q.size() > 0) begin
            $display("%s: only %0d output beats arrived, the rest timed out", name, cnt);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("PASS %s", name);
        end else begin
            failed++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic run_row(input int r);
        int          errs_before;
        bit          multi;
        logic [31:0] gaps;
        logic [31:0] stalls;
        errs_before = errors;
        multi = 1'b0;
        for (int len = row_first[r]; len <= row_last[r]; len++) begin
            build_frame(len, row_bad[r] && len == row_first[r]);
            multi = multi | (len > `FCS_LANES);
        end
        gaps = rand_bits(32);
        stalls = rand_bits(32);
        busy_seen = 1'b0;
        fork
            drive_beats(row_name[r], row_stall[r], gaps);
            collect_beats(row_name[r], row_stall[r], stalls);
        join
        @(posedge clk);
        check_flag({row_name[r], " busy after frame"}, 1'b0, busy);
        check_flag({row_name[r], " out_tvalid after frame"}, 1'b0, out_tvalid);
        if (multi) begin
            check_flag({row_name[r], " busy in frame"}, 1'b1, busy_seen);
        end
        report_test(row_name[r], errs_before);
    endtask

    initial begin
        int cyc;
        clk = 1'b0;
        rst = 1'b1;
        in_tdata = '0;
        in_tkeep = '0;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        out_tready = 1'b1;
        lfsr_q = 32'h026d_b34e;
        errors = 0;
        passed = 0;
        failed = 0;
        load_frame_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("reset_state out_tvalid", 1'b0, out_tvalid);
        check_flag("reset_state busy", 1'b0, busy);
        cyc = 0;
        while (!in_tready && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (!in_tready) begin
            $display("reset_state: in_tready never rose after reset");
            errors++;
        end
        report_test("reset_state", 0);
        for (int r = 0; r < row_name.size(); r++) begin
            run_row(r);
        end
        $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 passed, failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== eth_fcs_insert_64.f ====
+incdir+hdl
+incdir+tests
hdl/axis_types_pkg.sv
hdl/fcs_pkg.sv
hdl/eth_crc32_64.sv
hdl/fcs_tail_merge.sv
hdl/fcs_insert_fsm.sv
hdl/axis_skid_reg.sv
hdl/eth_fcs_insert_64.sv
tests/tb_eth_fcs_insert_64.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_eth_fcs_insert_64
FILELIST := eth_fcs_insert_64.f
OBJDIR   := obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf $(OBJDIR)
